// File: run.sh
#!/bin/sh
# build the fetch stage testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_if_stage -f verilog.f &&
./obj_dir/Vtb_if_stage | tee /dev/stderr | grep -q "STATUS: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

// File: sim/fetch_vectors.txt
# one command per line, arguments in hex: T n test, B addr branch, C n consume,
# S n consume with random stalls, E error entry next, H n halt req for n cycles, W n hold
T 1
B 00000100
C 8
T 2
S 20
W 20
T 3
B 00000200
B 00000300
C 4
B 00000400
C 2
T 4
B 00000FF0
C 4
E
B 00002000
C 3
T 5
H 30

// File: sim/instr_mem_model.sv
//////////////////////////////
// instruction memory model
//////////////////////////////

module instr_mem_model
  import fetch_pkg::*;
#(
  parameter int SEED = 32'h87bf
) (
  input  logic            clk,
  input  logic            rst_n,
  input  imem_req_t       req_i,
  output logic            gnt_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            rvalid_o,
  output logic            err_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [XLEN-1:0] PROT_LO  = 32'h0000_1000;
  localparam logic [XLEN-1:0] PROT_HI  = 32'h0000_10FF;
  localparam logic [XLEN-1:0] DATA_KEY = 32'hC0DE_0000;

  integer          seed;
  int unsigned     gnt_wait;
  int unsigned     rv_wait;
  int unsigned     delay;
  logic            pending;
  logic            prot;
  logic [XLEN-1:0] addr_q;

  // protected words answer at grant time, never with rvalid
  assign prot  = (req_i.addr >= PROT_LO) && (req_i.addr <= PROT_HI);
  assign err_o = gnt_o & req_i.req & prot;

  initial seed = SEED;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      pending  <= 1'b0;
      gnt_wait <= 0;
      rv_wait  <= 0;
      addr_q   <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (pending) begin
        if (rv_wait == 1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= addr_q ^ DATA_KEY;
          pending  <= 1'b0;
        end
        rv_wait <= rv_wait - 1;
      end
      if (req_i.req && gnt_o) begin
        // response 1 to 3 cycles after the grant cycle
        delay = 1 + $unsigned($random(seed)) % 3;
        if (!prot && delay == 1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= req_i.addr ^ DATA_KEY;
        end else if (!prot) begin
          pending <= 1'b1;
          rv_wait <= delay - 1;
          addr_q  <= req_i.addr;
        end
        // next grant waits 0 to 2 cycles, 0 leaves gnt high
        delay = $unsigned($random(seed)) % 3;
        gnt_wait <= delay;
        gnt_o    <= (delay == 0);
      end else if (req_i.req) begin
        if (gnt_wait <= 1) begin
          gnt_o <= 1'b1;
        end else begin
          gnt_wait <= gnt_wait - 1;
        end
      end
    end
  end

endmodule

// File: sim/tb_if_stage.sv
//////////////////////////////
// fetch stage testbench
//////////////////////////////

module tb_if_stage
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [XLEN-1:0] DATA_KEY = 32'hC0DE_0000;
  localparam int CYCLES_PER_LINE = 200;

  logic            clk;
  logic            rst_n;
  logic            req;
  logic            branch;
  logic [XLEN-1:0] branch_addr;
  logic            stall;
  imem_req_t       imem_req;
  logic            imem_gnt;
  logic [XLEN-1:0] imem_rdata;
  logic            imem_rvalid;
  logic            imem_err;
  logic            id_valid;
  fetch_entry_t    id_entry;
  logic            busy;

  integer          seed = 32'h87bf;
  integer          fd;
  logic [7:0]      cmd;
  logic [31:0]     arg;
  logic [8*128-1:0] line;
  logic [7:0]      cmds[$];
  logic [31:0]     args[$];
  int              n_lines = 0;
  int              test_num = 0;
  bit              test_open = 0;
  int              test_errs = 0;
  int              total_errs = 0;
  int              file_errs = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  logic [XLEN-1:0] exp_pc = '0;

  if_stage if_stage_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .stall_i       (stall),
    .imem_req_o    (imem_req),
    .imem_gnt_i    (imem_gnt),
    .imem_rdata_i  (imem_rdata),
    .imem_rvalid_i (imem_rvalid),
    .imem_err_i    (imem_err),
    .id_valid_o    (id_valid),
    .id_entry_o    (id_entry),
    .busy_o        (busy)
  );

  instr_mem_model #(
    .SEED     (32'h87bf)
  ) instr_mem_model_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (imem_req),
    .gnt_o    (imem_gnt),
    .rdata_o  (imem_rdata),
    .rvalid_o (imem_rvalid),
    .err_o    (imem_err)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic check_value(input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      test_errs++;
    end
  endtask

  // a normal entry carries the next sequential pc and its data word
  task automatic check_entry();
    check_value(exp_pc, id_entry.pc, "entry pc");
    check_value(exp_pc ^ DATA_KEY, id_entry.instr, "entry instr");
    check_value(0, id_entry.err, "entry err flag");
    exp_pc = exp_pc + 4;
  endtask

  task automatic close_test();
    if (test_open) begin
      if (test_errs == 0) begin
        $display("test %0d passed", test_num);
      end else begin
        $display("test %0d failed with %0d errors", test_num, test_errs);
        tests_failed++;
      end
      tests_run++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  //////////////////////////////
  // vector commands
  //////////////////////////////

  task automatic branch_to(input logic [XLEN-1:0] target);
    @(posedge clk);
    branch      <= 1'b1;
    branch_addr <= target;
    @(posedge clk);
    branch <= 1'b0;
    exp_pc = target;
  endtask

  // decode takes an entry at a rising edge where valid is high and stall low
  task automatic consume(input int n, input bit rnd);
    int got;
    int r;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      r = $random(seed);
      stall <= rnd ? r[0] : 1'b0;
      @(negedge clk);
      if (id_valid && !stall) begin
        check_entry();
        got++;
      end
    end
    // let the last one go, then hold the register
    @(posedge clk);
    stall <= 1'b1;
  endtask

  task automatic expect_error();
    bit seen;
    seen = 0;
    while (!seen) begin
      @(posedge clk);
      stall <= 1'b0;
      @(negedge clk);
      if (id_valid) begin
        check_value(1, id_entry.err, "error entry flag");
        check_value(exp_pc, id_entry.pc, "error entry pc");
        seen = 1;
      end
    end
    // fetch stays dead until the next branch
    repeat (20) begin
      @(negedge clk);
      check_value(0, id_valid, "valid after error entry");
    end
    check_value(0, busy, "busy after error entry");
    @(posedge clk);
    stall <= 1'b1;
  endtask

  // req low, whatever is buffered drains and the bus goes quiet
  task automatic drain(input int n);
    bit quiet;
    quiet = 0;
    @(posedge clk);
    req   <= 1'b0;
    stall <= 1'b0;
    repeat (n) begin
      @(negedge clk);
      if (id_valid) begin
        check_entry();
      end
      if (quiet) begin
        check_value(0, imem_req.req, "memory request while halted");
      end
      quiet = quiet | ~busy;
    end
    check_value(0, busy, "busy after drain");
    @(posedge clk);
    req   <= 1'b1;
    stall <= 1'b1;
  endtask

  // stage held, buffer settles at its almost full level
  task automatic hold(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (i >= n / 2) begin
        check_value(0, imem_req.req, "memory request while held");
        check_value(0, busy, "busy while held");
        check_value(1, id_valid, "held entry valid");
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n       = 1'b0;
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    stall       = 1'b1;
    fd = $fopen("sim/fetch_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file sim/fetch_vectors.txt");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while ($fscanf(fd, " %c", cmd) == 1) begin
        if (cmd == "#") begin
          void'($fgets(line, fd));
        end else begin
          arg = '0;
          if (cmd != "E") begin
            void'($fscanf(fd, " %h", arg));
          end
          if (!(cmd inside {"T", "B", "C", "S", "E", "H", "W"})) begin
            $display("unknown command %c in the vector file", cmd);
            file_errs++;
          end
          cmds.push_back(cmd);
          args.push_back(arg);
        end
      end
      $fclose(fd);
      n_lines = cmds.size();
      repeat (10) @(posedge clk);
      check_value(0, id_valid, "valid in reset");
      check_value(0, busy, "busy in reset");
      rst_n <= 1'b1;
      req   <= 1'b1;
      foreach (cmds[i]) begin
        case (cmds[i])
          "T": begin
            close_test();
            test_num  = args[i];
            test_open = 1;
          end
          "B": branch_to(args[i]);
          "C": consume(args[i], 1'b0);
          "S": consume(args[i], 1'b1);
          "E": expect_error();
          "H": drain(args[i]);
          "W": hold(args[i]);
          default: ;
        endcase
      end
      close_test();
      $display("%0d tests run, %0d failed, %0d check errors",
               tests_run, tests_failed, total_errs);
      if (total_errs == 0 && tests_failed == 0 && file_errs == 0 && tests_run > 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

  // budget grows with the length of the vector file
  initial begin
    wait (n_lines > 0);
    repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
    $display("timeout, the tests did not finish within %0d clock cycles",
             n_lines * CYCLES_PER_LINE);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
verilog/fetch_pkg.sv
verilog/fetch_fifo.sv
verilog/prefetch_buffer.sv
verilog/if_stage.sv
sim/instr_mem_model.sv
sim/tb_if_stage.sv

// File: verilog/fetch_fifo.sv
//////////////////////////////
// prefetch entry fifo
//////////////////////////////

module fetch_fifo
  import fetch_pkg::*;
#(
  parameter int unsigned DEPTH = BUF_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  fetch_entry_t               data_i,
  input  logic                       pop_i,
  output fetch_entry_t               data_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] usage_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  fetch_entry_t     mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push_ok;
  logic             pop_ok;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign usage_o = cnt_q;

  // head is registered, nothing falls through from data_i
  assign data_o = mem_q[rd_ptr_q];

  // a flush wins over any push or pop in the same cycle
  assign push_ok = push_i & ~full_o & ~flush_i;
  assign pop_ok  = pop_i & ~empty_o & ~flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // pointers wrap explicitly so any depth works
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push_ok) - CNT_W'(pop_ok);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: verilog/fetch_pkg.sv
//////////////////////////////
// fetch path shared types
//////////////////////////////

package fetch_pkg;

  // data and address width of the core
  localparam int unsigned XLEN = 32;

  // prefetch fifo depth, must be two or more
  localparam int unsigned BUF_DEPTH = 2;

  // fifo usage at which new memory requests stop
  localparam int unsigned BUF_ALM_FULL = BUF_DEPTH - 1;

  // one fetched word on its way to decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    // raw instruction word, zero on an error entry
    logic [XLEN-1:0] instr;
    // set when the fetch hit a protected address
    logic            err;
  } fetch_entry_t;

  // fetch fsm states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED,
    WAIT_ERR
  } fetch_state_e;

  // request side of the instruction memory bus
  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } imem_req_t;

endpackage

// File: verilog/if_stage.sv
//////////////////////////////
// instruction fetch stage
//////////////////////////////

module if_stage
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // core control
  input  logic            req_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,
  input  logic            stall_i,

  // instruction memory
  output imem_req_t       imem_req_o,
  input  logic            imem_gnt_i,
  input  logic [XLEN-1:0] imem_rdata_i,
  input  logic            imem_rvalid_i,
  input  logic            imem_err_i,

  // toward decode
  output logic            id_valid_o,
  output fetch_entry_t    id_entry_o,
  output logic            busy_o
);

  logic         pf_valid;
  logic         pf_ready;
  fetch_entry_t pf_entry;
  logic         id_valid_q;
  fetch_entry_t id_entry_q;

  // register takes a new entry when empty or when decode moves on
  assign pf_ready = ~(id_valid_q & stall_i);

  prefetch_buffer prefetch_buffer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (pf_ready),
    .valid_o       (pf_valid),
    .entry_o       (pf_entry),
    .imem_req_o    (imem_req_o),
    .imem_gnt_i    (imem_gnt_i),
    .imem_rdata_i  (imem_rdata_i),
    .imem_rvalid_i (imem_rvalid_i),
    .imem_err_i    (imem_err_i),
    .busy_o        (busy_o)
  );

  //////////////////////////////
  // IF/ID register
  //////////////////////////////

  // a branch kills whatever sits here or is arriving
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (branch_i) begin
      id_valid_q <= 1'b0;
    end else if (pf_ready) begin
      id_valid_q <= pf_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pf_ready & pf_valid) begin
      id_entry_q <= pf_entry;
    end
  end

  assign id_valid_o = id_valid_q;
  assign id_entry_o = id_entry_q;

endmodule

// File: verilog/prefetch_buffer.sv
//////////////////////////////
// instruction prefetch buffer
//////////////////////////////

module prefetch_buffer
  import fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  input  logic            req_i,
  input  logic            branch_i,
  input  logic [XLEN-1:0] branch_addr_i,

  input  logic            ready_i,
  output logic            valid_o,
  output fetch_entry_t    entry_o,

  // instruction memory port
  output imem_req_t       imem_req_o,
  input  logic            imem_gnt_i,
  input  logic [XLEN-1:0] imem_rdata_i,
  input  logic            imem_rvalid_i,
  input  logic            imem_err_i,

  output logic            busy_o
);

  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

  fetch_state_e     state_q;
  fetch_state_e     state_d;
  fetch_state_e     req_next;
  logic [XLEN-1:0]  addr_q;
  logic [XLEN-1:0]  fetch_addr;
  logic             addr_valid;
  logic             issue_ok;
  logic             err_done_q;
  logic             err_take;

  fetch_entry_t     fifo_in;
  fetch_entry_t     fifo_head;
  logic             fifo_push;
  logic             fifo_pop;
  logic             fifo_empty;
  logic             fifo_valid;
  logic             fifo_ready;
  logic             alm_full;
  logic [CNT_W-1:0] fifo_usage;

  // a request is in flight or being presented
  assign busy_o = (state_q inside {WAIT_GNT, WAIT_RVALID, WAIT_ABORTED}) | imem_req_o.req;

  // next sequential word after the last issued address
  assign fetch_addr = {addr_q[XLEN-1:2], 2'b00} + XLEN'(4);

  // sequential fetch waits for buffer space but a branch always fetches
  assign issue_ok = branch_i | (req_i & fifo_ready);

  // where a presented request goes next
  // err only comes together with gnt
  assign req_next = !imem_gnt_i ? WAIT_GNT :
                    imem_err_i  ? WAIT_ERR : WAIT_RVALID;

  //////////////////////////////
  // fetch fsm
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    imem_req_o.req  = 1'b0;
    imem_req_o.addr = branch_i ? branch_addr_i : fetch_addr;
    addr_valid      = 1'b0;
    fifo_push       = 1'b0;

    unique case (state_q)
      // nothing outstanding
      IDLE: begin
        if (issue_ok) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = req_next;
        end
      end

      // hold req and address until granted unless a branch replaces the address
      WAIT_GNT: begin
        imem_req_o.req = 1'b1;
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          imem_req_o.addr = addr_q;
        end
        state_d = req_next;
      end

      // one word outstanding with addr_q as its pc
      WAIT_RVALID: begin
        if (imem_rvalid_i) begin
          // buffer the word unless it can go straight to the consumer
          fifo_push = fifo_valid | ~ready_i;
          if (issue_ok) begin
            imem_req_o.req = 1'b1;
            addr_valid     = 1'b1;
            state_d        = req_next;
          end else begin
            state_d = IDLE;
          end
        end else if (branch_i) begin
          // the response still on its way gets dropped when it arrives
          addr_valid = 1'b1;
          state_d    = WAIT_ABORTED;
        end
      end

      // stale word pending while addr_q already holds the branch target
      WAIT_ABORTED: begin
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          imem_req_o.addr = addr_q;
        end
        if (imem_rvalid_i) begin
          imem_req_o.req = 1'b1;
          state_d        = req_next;
        end
      end

      // after a protected address hit only a branch restarts fetching
      WAIT_ERR: begin
        if (branch_i) begin
          imem_req_o.req = 1'b1;
          addr_valid     = 1'b1;
          state_d        = req_next;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // state and address
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      addr_q     <= '0;
      err_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        addr_q <= imem_req_o.addr;
      end
      // error entry goes out once per WAIT_ERR visit
      err_done_q <= (state_q == WAIT_ERR) & ~branch_i & (err_done_q | err_take);
    end
  end

  //////////////////////////////
  // buffer and output mux
  //////////////////////////////

  assign fifo_in    = '{pc: addr_q, instr: imem_rdata_i, err: 1'b0};
  assign fifo_valid = ~fifo_empty;
  assign alm_full   = (fifo_usage >= CNT_W'(BUF_ALM_FULL));
  assign fifo_ready = ~alm_full;

  fetch_fifo #(
    .DEPTH   (BUF_DEPTH)
  ) fetch_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (fifo_push),
    .data_i  (fifo_in),
    .pop_i   (fifo_pop),
    .data_o  (fifo_head),
    .empty_o (fifo_empty),
    .full_o  (),
    .usage_o (fifo_usage)
  );

  // older buffered words go ahead of the error entry and the live word
  always_comb begin
    fifo_pop      = 1'b0;
    err_take      = 1'b0;
    valid_o       = 1'b0;
    entry_o.pc    = addr_q;
    entry_o.instr = imem_rdata_i & {XLEN{imem_rvalid_i}};
    entry_o.err   = 1'b0;
    if (fifo_valid) begin
      entry_o  = fifo_head;
      valid_o  = 1'b1;
      fifo_pop = ready_i;
    end else if (state_q == WAIT_ERR) begin
      entry_o.instr = '0;
      entry_o.err   = 1'b1;
      valid_o       = ~err_done_q;
      err_take      = ~err_done_q & ready_i;
    end else begin
      // aborted responses never reach the consumer
      valid_o = imem_rvalid_i & (state_q == WAIT_RVALID);
    end
  end

endmodule
